// File: Makefile
TOP := wave_channel_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f logic/*.sv verification/*.sv
	verilator --binary --timing -f build.f --top-module $(TOP) -o V$(TOP)

# The log decides pass or fail
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
logic/wave_pkg.sv
logic/wave_cfg_if.sv
logic/wave_channel_ctrl.sv
logic/wave_ram.sv
logic/wave_freq_timer.sv
logic/wave_length_ctr.sv
logic/wave_sample_out.sv
logic/wave_channel_top.sv
verification/wave_channel_tb.sv

// File: logic/wave_cfg_if.sv
`default_nettype none

interface wave_cfg_if
    import wave_pkg::*;
;
    // Configuration from the register file
    freq_t   frequency;
    length_t length;
    volume_t volume;
    logic    on;
    logic    single;
    // One cycle restart pulse
    logic    trigger;
    // Channel running, owned by the length counter
    logic    enable;

    modport ctrl (
        output frequency, length, volume, on, single, trigger,
        input  enable
    );

    modport timer (input frequency, trigger);

    modport len (
        input  length, on, single, trigger,
        output enable
    );

    modport sample (input volume, on, trigger, enable);

endinterface

`default_nettype wire

// File: logic/wave_channel_ctrl.sv
`default_nettype none

module wave_channel_ctrl
    import wave_pkg::*;
(
    input  logic       clk_pointer_inc,
    input  logic       start,
    input  apb_addr_t  paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    wave_cfg_if.ctrl   cfg,
    output logic       ram_we,
    output wave_addr_t ram_waddr,
    output wave_byte_t ram_wdata,
    input  wave_byte_t ram_rdata
);

    apb_state_t state;
    apb_state_t state_nxt;
    logic       access;
    logic       wr_en;
    logic       rd_en;
    logic       in_wave;
    logic       on_q;
    logic       single_q;
    logic       trigger_q;
    length_t    length_q;
    volume_t    volume_q;
    freq_t      freq_q;
    apb_data_t  reg_rdata;

    ////////////////////
    // APB phase FSM
    ////////////////////

    // State holds the phase of the cycle just finished
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (psel && !penable)
                    state_nxt = SETUP;
            end
            SETUP: begin
                if (psel && penable)
                    state_nxt = ACCESS;
                else if (!psel)
                    state_nxt = IDLE;
            end
            ACCESS: begin
                // Back to back transfer starts a new setup
                if (psel && !penable)
                    state_nxt = SETUP;
                else
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // Access cycle only after a proper setup
    assign access  = (state == SETUP) && psel && penable;
    assign wr_en   = access && pwrite;
    assign rd_en   = access && !pwrite;
    assign in_wave = (paddr[5:4] == WAVE_BASE[5:4]);

    // No wait states, no errors
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    ////////////////////
    // Register file
    ////////////////////

    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            on_q      <= 1'b0;
            single_q  <= 1'b0;
            trigger_q <= 1'b0;
            length_q  <= '0;
            volume_q  <= '0;
            freq_q    <= '0;
        end else begin
            // Trigger lasts one cycle only
            trigger_q <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    REG_CTRL:    on_q <= pwdata[7];
                    REG_LENGTH:  length_q <= pwdata;
                    REG_VOLUME:  volume_q <= pwdata[6:5];
                    REG_FREQ_LO: freq_q[7:0] <= pwdata;
                    REG_FREQ_HI: begin
                        freq_q[10:8] <= pwdata[2:0];
                        single_q     <= pwdata[6];
                        trigger_q    <= pwdata[7];
                    end
                    // Status and unmapped offsets ignore writes
                    default: ;
                endcase
            end
        end
    end

    assign cfg.frequency = freq_q;
    assign cfg.length    = length_q;
    assign cfg.volume    = volume_q;
    assign cfg.on        = on_q;
    assign cfg.single    = single_q;
    assign cfg.trigger   = trigger_q;

    // Wave window goes straight to the RAM
    assign ram_we    = wr_en && in_wave;
    assign ram_waddr = paddr[3:0];
    assign ram_wdata = pwdata;

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        reg_rdata = '0;
        case (paddr)
            REG_CTRL:    reg_rdata = {on_q, 7'b0};
            REG_LENGTH:  reg_rdata = length_q;
            REG_VOLUME:  reg_rdata = {1'b0, volume_q, 5'b0};
            REG_FREQ_LO: reg_rdata = freq_q[7:0];
            // Trigger bit always reads zero
            REG_FREQ_HI: reg_rdata = {1'b0, single_q, 3'b0, freq_q[10:8]};
            REG_STATUS:  reg_rdata = {7'b0, cfg.enable};
            default: begin
                if (in_wave)
                    reg_rdata = ram_rdata;
            end
        endcase
    end

    assign prdata = rd_en ? reg_rdata : '0;

endmodule

`default_nettype wire

// File: logic/wave_channel_top.sv
`default_nettype none

module wave_channel_top
    import wave_pkg::*;
(
    input  logic      clk_pointer_inc,
    input  logic      start,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output sample_t   level,
    output logic      enable
);

    logic       ram_we;
    wave_addr_t ram_waddr;
    wave_byte_t ram_wdata;
    wave_byte_t ram_rdata;
    wave_addr_t wave_a;
    wave_byte_t wave_d;
    logic       step;

    // Channel configuration and status
    wave_cfg_if cfg_bus ();

    ////////////////////
    // CPU side
    ////////////////////

    wave_channel_ctrl ctrl_inst (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .cfg             (cfg_bus.ctrl),
        .ram_we          (ram_we),
        .ram_waddr       (ram_waddr),
        .ram_wdata       (ram_wdata),
        .ram_rdata       (ram_rdata)
    );

    // CPU reads share the write address
    wave_ram ram_inst (
        .clk_pointer_inc (clk_pointer_inc),
        .we              (ram_we),
        .waddr           (ram_waddr),
        .wdata           (ram_wdata),
        .cpu_addr        (ram_waddr),
        .cpu_data        (ram_rdata),
        .wave_a          (wave_a),
        .wave_d          (wave_d)
    );

    ////////////////////
    // Playback side
    ////////////////////

    wave_freq_timer timer_inst (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .cfg             (cfg_bus.timer),
        .step            (step)
    );

    wave_length_ctr length_inst (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .cfg             (cfg_bus.len)
    );

    wave_sample_out sample_inst (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .cfg             (cfg_bus.sample),
        .step            (step),
        .wave_a          (wave_a),
        .wave_d          (wave_d),
        .level           (level)
    );

    assign enable = cfg_bus.enable;

endmodule

`default_nettype wire

// File: logic/wave_freq_timer.sv
`default_nettype none

module wave_freq_timer
    import wave_pkg::*;
(
    input  logic      clk_pointer_inc,
    input  logic      start,
    wave_cfg_if.timer cfg,
    output logic      step
);

    freq_t cnt;

    // Counts up from frequency to 2047
    // Period is 2048 minus frequency cycles
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            cnt  <= '0;
            step <= 1'b0;
        end else if (cfg.trigger) begin
            // Restart the period on trigger
            cnt  <= cfg.frequency;
            step <= 1'b0;
        end else if (cnt == '1) begin
            // Wrap reloads and paces the pointer
            cnt  <= cfg.frequency;
            step <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            step <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/wave_length_ctr.sv
`default_nettype none

module wave_length_ctr
    import wave_pkg::*;
(
    input  logic    clk_pointer_inc,
    input  logic    start,
    wave_cfg_if.len cfg
);

    tick_cnt_t presc;
    logic      tick;
    length_t   cnt;
    logic      enable_q;

    ////////////////////
    // Tick prescaler
    ////////////////////

    // Free running from reset
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start)
            presc <= '0;
        else
            presc <= presc + 1'b1;
    end

    assign tick = (presc == tick_cnt_t'(LENGTH_TICK_DIV - 1));

    ////////////////////
    // Length counter and enable
    ////////////////////

    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            cnt      <= '0;
            enable_q <= 1'b0;
        end else if (cfg.trigger) begin
            cnt      <= cfg.length;
            // Only starts when the channel is powered
            enable_q <= cfg.on;
        end else begin
            if (tick && cfg.single) begin
                cnt <= cnt + 1'b1;
                // Overflow 255 to 0 ends the sound
                if (cnt == '1)
                    enable_q <= 1'b0;
            end
            // Power off wins
            if (!cfg.on)
                enable_q <= 1'b0;
        end
    end

    assign cfg.enable = enable_q;

endmodule

`default_nettype wire

// File: logic/wave_pkg.sv
`default_nettype none

package wave_pkg;

    ////////////////////
    // Widths with a meaning
    ////////////////////

    // Period is 2048 minus this value
    typedef logic [10:0] freq_t;
    // Channel runs 256 minus this value ticks
    typedef logic [7:0]  length_t;
    typedef logic [1:0]  volume_t;
    // One sample, also the output level
    typedef logic [3:0]  sample_t;
    typedef logic [3:0]  wave_addr_t;
    // Two samples, upper nibble played first
    typedef logic [7:0]  wave_byte_t;
    typedef logic [5:0]  apb_addr_t;
    typedef logic [7:0]  apb_data_t;

    ////////////////////
    // Register map
    ////////////////////

    localparam apb_addr_t REG_CTRL    = 6'h00;
    localparam apb_addr_t REG_LENGTH  = 6'h01;
    localparam apb_addr_t REG_VOLUME  = 6'h02;
    localparam apb_addr_t REG_FREQ_LO = 6'h03;
    localparam apb_addr_t REG_FREQ_HI = 6'h04;
    localparam apb_addr_t REG_STATUS  = 6'h05;
    // Wave RAM window 0x20 to 0x2F
    localparam apb_addr_t WAVE_BASE   = 6'h20;

    // Volume codes
    localparam volume_t VOL_MUTE    = 2'd0;
    localparam volume_t VOL_FULL    = 2'd1;
    localparam volume_t VOL_HALF    = 2'd2;
    localparam volume_t VOL_QUARTER = 2'd3;

    // Length tick prescaler, scaled down for simulation
    localparam int LENGTH_TICK_DIV = 64;
    localparam int LENGTH_TICK_W   = $clog2(LENGTH_TICK_DIV);
    typedef logic [LENGTH_TICK_W-1:0] tick_cnt_t;

    // APB phase tracking
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

endpackage

`default_nettype wire

// File: logic/wave_ram.sv
`default_nettype none

module wave_ram
    import wave_pkg::*;
(
    input  logic       clk_pointer_inc,
    input  logic       we,
    input  wave_addr_t waddr,
    input  wave_byte_t wdata,
    input  wave_addr_t cpu_addr,
    output wave_byte_t cpu_data,
    input  wave_addr_t wave_a,
    output wave_byte_t wave_d
);

    // 32 four bit samples packed two per byte
    wave_byte_t mem [16];

    ////////////////////
    // CPU write port
    ////////////////////

    always_ff @(posedge clk_pointer_inc) begin
        if (we)
            mem[waddr] <= wdata;
    end

    ////////////////////
    // Read ports
    ////////////////////

    // CPU side for APB reads
    assign cpu_data = mem[cpu_addr];

    // Playback side, never stalled by CPU writes
    assign wave_d = mem[wave_a];

endmodule

`default_nettype wire

// File: logic/wave_sample_out.sv
`default_nettype none

module wave_sample_out
    import wave_pkg::*;
(
    input  logic       clk_pointer_inc,
    input  logic       start,
    wave_cfg_if.sample cfg,
    input  logic       step,
    output wave_addr_t wave_a,
    input  wave_byte_t wave_d,
    output sample_t    level
);

    logic [4:0] ptr;
    sample_t    sample;
    sample_t    scaled;

    ////////////////////
    // Sample pointer
    ////////////////////

    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start)
            ptr <= '0;
        else if (cfg.trigger)
            ptr <= '0;
        else if (step && cfg.on)
            // Wraps after 32 samples
            ptr <= ptr + 1'b1;
    end

    // Upper bits pick the byte
    assign wave_a = ptr[4:1];
    // Even pointer plays the upper nibble
    assign sample = ptr[0] ? wave_d[3:0] : wave_d[7:4];

    ////////////////////
    // Volume and output
    ////////////////////

    always_comb begin
        case (cfg.volume)
            VOL_MUTE:    scaled = '0;
            VOL_FULL:    scaled = sample;
            VOL_HALF:    scaled = sample >> 1;
            VOL_QUARTER: scaled = sample >> 2;
            default:     scaled = '0;
        endcase
    end

    // Silent unless powered and running
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start)
            level <= '0;
        else if (cfg.on && cfg.enable)
            level <= scaled;
        else
            level <= '0;
    end

endmodule

`default_nettype wire

// File: verification/wave_cases.txt
# Columns: command word, then operands in hex except the play count
# wave b0..b15 | write addr data | read addr expect | play count | expect_off len | end
wave 4C 93 5D A0 6E B1 7F 82 4E A3 5C B0 6D 91 7C A2
write 00 80
write 01 FC
write 02 20
write 03 F0
write 04 47
read 00 80
read 01 FC
read 02 20
read 03 F0
read 04 47
read 06 00
read 3F 00
write 04 87
play 40
play 5
write 04 87
play 6
read 04 07
write 02 40
write 04 87
play 40
write 02 60
write 04 87
play 40
write 02 00
write 04 87
play 0
write 02 20
write 04 C7
expect_off FC
write 04 87
expect_off FC
write 00 00
read 05 00
end

// File: verification/wave_channel_tb.sv
`default_nettype none

module wave_channel_tb
    import wave_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam int          APB_TIMEOUT  = 16;
    localparam int unsigned SEED         = 32'h4998_91c6;
    localparam string       CASES_FILE   = "verification/wave_cases.txt";

    logic      clk_pointer_inc;
    logic      start;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    sample_t   level;
    logic      enable;

    // Reference copy of what the CPU has written
    wave_byte_t wave_model [16];
    volume_t    vol_m;
    freq_t      freq_m;
    logic       single_m;
    // Next expected sample position
    int         ptr_m;
    // Set only between a trigger write and the next transfer
    logic       just_triggered;

    int                 fd;
    string              cmd;
    logic [8*160-1:0]   skip_line;

    wave_channel_top wave_channel_top_inst (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .level           (level),
        .enable          (enable)
    );

    always #(CLK_PERIOD / 2) clk_pointer_inc = ~clk_pointer_inc;

    ////////////////////
    // Failure paths
    ////////////////////

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s at time %0t", what, $time);
        abort_run();
    endtask

    task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
    endtask

    task automatic check_level(input sample_t got, input sample_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: level %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_enable(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    ////////////////////
    // APB transfers
    ////////////////////

    // Starts and ends on a falling edge
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata);
        int gap;
        int waited;
        gap = int'($urandom_range(3, 0));
        repeat (gap) @(negedge clk_pointer_inc);
        // Setup cycle
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_pointer_inc);
        // Access cycle, sampled a quarter period in
        penable = 1'b1;
        waited  = 0;
        #(CLK_PERIOD / 4);
        while (pready !== 1'b1) begin
            @(negedge clk_pointer_inc);
            #(CLK_PERIOD / 4);
            waited++;
            if (waited > APB_TIMEOUT)
                report_timeout("pready in the access cycle");
        end
        rdata = prdata;
        check_enable(pslverr, 1'b0, "pslverr");
        @(negedge clk_pointer_inc);
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        just_triggered = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused);
        // Track the register map rules
        case (addr)
            REG_VOLUME:  vol_m = data[6:5];
            REG_FREQ_LO: freq_m[7:0] = data;
            REG_FREQ_HI: begin
                freq_m[10:8] = data[2:0];
                single_m     = data[6];
                if (data[7]) begin
                    ptr_m          = 0;
                    just_triggered = 1'b1;
                end
            end
            default: begin
                if (addr[5:4] == 2'b10)
                    wave_model[addr[3:0]] = data;
            end
        endcase
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        apb_transfer(1'b0, addr, 8'h00, data);
    endtask

    ////////////////////
    // Playback checks
    ////////////////////

    // Nibble at a pointer, scaled by the volume code
    function automatic sample_t expected_level(input int ptr);
        wave_byte_t b;
        sample_t    nib;
        b   = wave_model[ptr[4:1]];
        nib = ptr[0] ? b[3:0] : b[7:4];
        case (vol_m)
            2'd0:    return 4'd0;
            2'd1:    return nib;
            2'd2:    return nib >> 1;
            default: return nib >> 2;
        endcase
    endfunction

    task automatic play_and_check(input int count);
        sample_t prev;
        int      recorded;
        int      waited;
        int      period;
        period   = 2048 - int'(freq_m);
        recorded = 0;
        if (count == 0) begin
            // Muted, level must stay quiet for three periods
            repeat (2) @(negedge clk_pointer_inc);
            for (int i = 0; i < 3 * period; i++) begin
                check_level(level, 4'd0, "muted level");
                @(negedge clk_pointer_inc);
            end
        end else begin
            if (just_triggered) begin
                // Level holds byte 0 upper nibble two edges after the write
                repeat (2) @(negedge clk_pointer_inc);
                check_level(level, expected_level(ptr_m), "first level after trigger");
                ptr_m    = (ptr_m + 1) % 32;
                recorded = 1;
            end
            prev = level;
            while (recorded < count) begin
                waited = 0;
                while (level === prev) begin
                    @(negedge clk_pointer_inc);
                    waited++;
                    if (waited > 3 * period + 8)
                        report_timeout("a level change");
                end
                check_level(level, expected_level(ptr_m),
                            $sformatf("level change %0d", recorded));
                prev     = level;
                ptr_m    = (ptr_m + 1) % 32;
                recorded++;
            end
        end
        just_triggered = 1'b0;
    endtask

    task automatic expect_length_expiry(input length_t len);
        int        cycles;
        int        lo;
        int        hi;
        apb_data_t rd;
        // Fall window in cycles after the trigger
        lo = (255 - int'(len)) * LENGTH_TICK_DIV;
        hi = (256 - int'(len)) * LENGTH_TICK_DIV + 2;
        repeat (2) @(negedge clk_pointer_inc);
        cycles = 2;
        check_enable(enable, 1'b1, "enable after trigger");
        if (single_m) begin
            while (enable === 1'b1) begin
                @(negedge clk_pointer_inc);
                cycles++;
                if (cycles > hi)
                    report_timeout("enable to fall after the length ran out");
            end
            if (cycles < lo)
                report_mismatch($sformatf("enable fell after %0d cycles, window starts at %0d",
                                          cycles, lo));
            repeat (2) @(negedge clk_pointer_inc);
            check_level(level, 4'd0, "level after expiry");
            apb_read(REG_STATUS, rd);
            check_data(rd, 8'h00, "status after expiry");
        end else begin
            // No length counting, channel keeps running
            while (cycles <= hi) begin
                @(negedge clk_pointer_inc);
                cycles++;
                check_enable(enable, 1'b1, "enable with single clear");
            end
            apb_read(REG_STATUS, rd);
            check_data(rd, 8'h01, "status while running");
        end
        just_triggered = 1'b0;
    endtask

    ////////////////////
    // Scenario file
    ////////////////////

    task automatic read_hex(output logic [31:0] value);
        if ($fscanf(fd, "%h", value) != 1) begin
            $display("Missing hex operand in %s", CASES_FILE);
            abort_run();
        end
    endtask

    task automatic read_dec(output int value);
        if ($fscanf(fd, "%d", value) != 1) begin
            $display("Missing count operand in %s", CASES_FILE);
            abort_run();
        end
    endtask

    initial begin
        apb_data_t   rd;
        logic [31:0] a;
        logic [31:0] d;
        int          n;
        wave_byte_t  bytes [16];
        logic        done;
        void'($urandom(SEED));
        clk_pointer_inc = 1'b0;
        start           = 1'b1;
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        vol_m           = '0;
        freq_m          = '0;
        single_m        = 1'b0;
        ptr_m           = 0;
        just_triggered  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_pointer_inc);
        start = 1'b0;

        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s", CASES_FILE);
            abort_run();
        end
        done = 1'b0;
        while (!done) begin
            if ($fscanf(fd, "%s", cmd) != 1) begin
                $display("%s ended without an end line", CASES_FILE);
                abort_run();
            end
            if (cmd == "#") begin
                void'($fgets(skip_line, fd));
            end else if (cmd == "wave") begin
                // Load all 16 bytes, then read each one back
                for (int i = 0; i < 16; i++) begin
                    read_hex(d);
                    bytes[i] = wave_byte_t'(d);
                end
                for (int i = 0; i < 16; i++)
                    apb_write(WAVE_BASE | apb_addr_t'(i), bytes[i]);
                for (int i = 0; i < 16; i++) begin
                    apb_read(WAVE_BASE | apb_addr_t'(i), rd);
                    check_data(rd, bytes[i], $sformatf("wave byte %0d", i));
                end
            end else if (cmd == "write") begin
                read_hex(a);
                read_hex(d);
                apb_write(apb_addr_t'(a), apb_data_t'(d));
                // Power off must silence the channel quickly
                if (apb_addr_t'(a) == REG_CTRL && d[7] == 1'b0) begin
                    repeat (2) @(negedge clk_pointer_inc);
                    check_enable(enable, 1'b0, "enable after power off");
                    check_level(level, 4'd0, "level after power off");
                end
            end else if (cmd == "read") begin
                read_hex(a);
                read_hex(d);
                apb_read(apb_addr_t'(a), rd);
                check_data(rd, apb_data_t'(d), $sformatf("read of 0x%02h", a[5:0]));
            end else if (cmd == "play") begin
                read_dec(n);
                play_and_check(n);
            end else if (cmd == "expect_off") begin
                read_hex(d);
                expect_length_expiry(length_t'(d));
            end else if (cmd == "end") begin
                done = 1'b1;
            end else begin
                $display("Unknown command %s in %s", cmd, CASES_FILE);
                abort_run();
            end
        end
        $fclose(fd);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
